// ==== common/soc_cfg_pkg.sv ====
`default_nettype none

package soc_cfg_pkg;

  // Cluster scratch memory, stands in for the TCDM
  localparam int unsigned MEM_WORDS = 256;
  localparam int unsigned ADDR_W    = 8;
  localparam int unsigned DATA_W    = 32;

  // Host side limit on requests in flight
  localparam int unsigned MAX_TXNS = 4;

  // Both clock domain crossings use 8 entries
  localparam int unsigned FIFO_LOG_DEPTH = 3;

  // Word address, no byte lanes
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic              we;
  } mem_req_t;

  // Writes echo the stored word back
  typedef struct packed {
    logic [DATA_W-1:0] rdata;
  } mem_rsp_t;

endpackage

`default_nettype wire

// ==== common/padframe_pkg.sv ====
`default_nettype none

package padframe_pkg;

  localparam int unsigned N_PADS = 8;

  // Function select per pad
  localparam int unsigned SEL_W = 2;

  typedef logic [SEL_W-1:0] pad_sel_t;

  localparam pad_sel_t SEL_GPIO = 2'd0;
  localparam pad_sel_t SEL_UART = 2'd1;
  localparam pad_sel_t SEL_SPI  = 2'd2;
  localparam pad_sel_t SEL_I2C  = 2'd3;

  // Register map: address p holds the select of pad p,
  // everything from N_PADS up is unmapped and reads zero
  localparam int unsigned CFG_ADDR_W = 4;

endpackage

`default_nettype wire

// ==== cdc/cdc_fifo_gray.sv ====
`default_nettype none

module cdc_fifo_gray #(
  parameter type payload_t = logic
) (
  input  wire           wr_clk_i,
  input  wire           rd_clk_i,
  input  wire           rst_n_i,
  // Write side, wr_clk_i
  input  wire           wr_valid_i,
  input  wire payload_t wr_data_i,
  output logic          wr_full_o,
  // Read side, rd_clk_i
  output logic          rd_valid_o,
  input  wire           rd_ready_i,
  output payload_t      rd_data_o
);

  localparam int unsigned LOG_DEPTH = soc_cfg_pkg::FIFO_LOG_DEPTH;
  localparam int unsigned DEPTH     = 2 ** LOG_DEPTH;
  // One extra bit tells a full FIFO from an empty one
  localparam int unsigned PTR_W     = LOG_DEPTH + 1;

  payload_t mem_q [DEPTH];

  logic [PTR_W-1:0] wr_bin_q;
  logic [PTR_W-1:0] wr_gray_q;
  logic [PTR_W-1:0] wr_bin_d;
  logic [PTR_W-1:0] rd_gray_sync1_q;
  logic [PTR_W-1:0] rd_gray_sync2_q;
  logic             wr_push;

  logic [PTR_W-1:0] rd_bin_q;
  logic [PTR_W-1:0] rd_gray_q;
  logic [PTR_W-1:0] rd_bin_d;
  logic [PTR_W-1:0] wr_gray_sync1_q;
  logic [PTR_W-1:0] wr_gray_sync2_q;
  logic             rd_pop;

  // Write domain
  assign wr_full_o = wr_gray_q == {~rd_gray_sync2_q[PTR_W-1:PTR_W-2],
                                   rd_gray_sync2_q[PTR_W-3:0]};
  assign wr_push   = wr_valid_i && !wr_full_o;
  assign wr_bin_d  = wr_bin_q + 1'b1;

  always_ff @(posedge wr_clk_i) begin
    if (!rst_n_i) begin
      wr_bin_q        <= '0;
      wr_gray_q       <= '0;
      rd_gray_sync1_q <= '0;
      rd_gray_sync2_q <= '0;
    end else begin
      rd_gray_sync1_q <= rd_gray_q;
      rd_gray_sync2_q <= rd_gray_sync1_q;
      if (wr_push) begin
        wr_bin_q  <= wr_bin_d;
        wr_gray_q <= wr_bin_d ^ (wr_bin_d >> 1);
      end
    end
  end

  always_ff @(posedge wr_clk_i) begin
    if (wr_push) begin
      mem_q[wr_bin_q[LOG_DEPTH-1:0]] <= wr_data_i;
    end
  end

  // Read domain
  // Entry is written well before its pointer update gets through the synchronizer
  assign rd_valid_o = rd_gray_q != wr_gray_sync2_q;
  assign rd_pop     = rd_valid_o && rd_ready_i;
  assign rd_bin_d   = rd_bin_q + 1'b1;
  assign rd_data_o  = mem_q[rd_bin_q[LOG_DEPTH-1:0]];

  always_ff @(posedge rd_clk_i) begin
    if (!rst_n_i) begin
      rd_bin_q        <= '0;
      rd_gray_q       <= '0;
      wr_gray_sync1_q <= '0;
      wr_gray_sync2_q <= '0;
    end else begin
      wr_gray_sync1_q <= wr_gray_q;
      wr_gray_sync2_q <= wr_gray_sync1_q;
      if (rd_pop) begin
        rd_bin_q  <= rd_bin_d;
        rd_gray_q <= rd_bin_d ^ (rd_bin_d >> 1);
      end
    end
  end

  // Upstream has to respect full, dropped writes would lose a transaction
  a_no_write_when_full: assert property (@(posedge wr_clk_i) disable iff (!rst_n_i)
    wr_valid_i |-> !wr_full_o);

endmodule

`default_nettype wire

// ==== hw/txn_serializer.sv ====
`default_nettype none

module txn_serializer (
  input  wire  clk_i,
  input  wire  rst_n_i,
  input  wire  req_valid_i,
  output logic req_ready_o,
  input  wire  fifo_full_i,
  output logic fifo_push_o,
  input  wire  rsp_pop_i
);

  localparam int unsigned CNT_W = $clog2(soc_cfg_pkg::MAX_TXNS + 1);
  localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(soc_cfg_pkg::MAX_TXNS);

  // Requests accepted minus responses handed to the host
  logic [CNT_W-1:0] cnt_q;
  logic [CNT_W-1:0] cnt_d;

  assign req_ready_o = (cnt_q != CNT_MAX) && !fifo_full_i;
  assign fifo_push_o = req_valid_i && req_ready_o;

  always_comb begin
    cnt_d = cnt_q;
    case ({fifo_push_o, rsp_pop_i})
      2'b10:   cnt_d = cnt_q + 1'b1;
      2'b01:   cnt_d = cnt_q - 1'b1;
      default: cnt_d = cnt_q;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  // Limit holds across both crossings and the host response stall
  a_cnt_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cnt_q <= CNT_MAX);

  // A response always belongs to a request still counted
  a_no_orphan_rsp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_pop_i |-> cnt_q != '0);

endmodule

`default_nettype wire

// ==== hw/cluster_mem.sv ====
`default_nettype none

module cluster_mem (
  input  wire                   clk_i,
  input  wire                   rst_n_i,
  input  wire                   req_valid_i,
  input  wire soc_cfg_pkg::mem_req_t req_i,
  output logic                  req_pop_o,
  input  wire                   rsp_full_i,
  output logic                  rsp_push_o,
  output soc_cfg_pkg::mem_rsp_t rsp_o
);

  logic [soc_cfg_pkg::DATA_W-1:0] mem_q [soc_cfg_pkg::MEM_WORDS];

  logic                  rsp_valid_q;
  soc_cfg_pkg::mem_rsp_t rsp_q;

  // Response register drains in the same cycle a new request is taken,
  // so both just wait on the response FIFO
  assign req_pop_o  = req_valid_i && !rsp_full_i;
  assign rsp_push_o = rsp_valid_q && !rsp_full_i;
  assign rsp_o      = rsp_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else if (!rsp_full_i) begin
      rsp_valid_q <= req_pop_o;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_pop_o) begin
      if (req_i.we) begin
        mem_q[req_i.addr] <= req_i.wdata;
        rsp_q.rdata       <= req_i.wdata;
      end else begin
        rsp_q.rdata <= mem_q[req_i.addr];
      end
    end
  end

endmodule

`default_nettype wire

// ==== padframe/padframe_cfg_regs.sv ====
`default_nettype none

module padframe_cfg_regs (
  input  wire                                         clk_i,
  input  wire                                         rst_n_i,
  input  wire                                         cfg_valid_i,
  input  wire                                         cfg_write_i,
  input  wire  [padframe_pkg::CFG_ADDR_W-1:0]         cfg_addr_i,
  input  wire  padframe_pkg::pad_sel_t                cfg_wdata_i,
  output logic                                        cfg_rvalid_o,
  output padframe_pkg::pad_sel_t                      cfg_rdata_o,
  output padframe_pkg::pad_sel_t [padframe_pkg::N_PADS-1:0] pad_sel_o
);

  localparam int unsigned IDX_W = $clog2(padframe_pkg::N_PADS);

  padframe_pkg::pad_sel_t [padframe_pkg::N_PADS-1:0] sel_q;

  logic                   addr_hit;
  logic [IDX_W-1:0]       pad_idx;
  logic                   rvalid_q;
  padframe_pkg::pad_sel_t rdata_q;

  // Decode
  assign addr_hit = cfg_addr_i < padframe_pkg::CFG_ADDR_W'(padframe_pkg::N_PADS);
  assign pad_idx  = cfg_addr_i[IDX_W-1:0];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sel_q <= {padframe_pkg::N_PADS{padframe_pkg::SEL_GPIO}};
    end else if (cfg_valid_i && cfg_write_i && addr_hit) begin
      sel_q[pad_idx] <= cfg_wdata_i;
    end
  end

  // Read data comes back one cycle after the request
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= cfg_valid_i && !cfg_write_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cfg_valid_i && !cfg_write_i) begin
      rdata_q <= addr_hit ? sel_q[pad_idx] : '0;
    end
  end

  assign cfg_rvalid_o = rvalid_q;
  assign cfg_rdata_o  = rdata_q;
  assign pad_sel_o    = sel_q;

  a_addr_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cfg_valid_i |-> !$isunknown(cfg_addr_i));

endmodule

`default_nettype wire

// ==== padframe/padframe_mux.sv ====
`default_nettype none

module padframe_mux (
  input  wire padframe_pkg::pad_sel_t [padframe_pkg::N_PADS-1:0] pad_sel_i,
  input  wire  [padframe_pkg::N_PADS-1:0] gpio_out_i,
  input  wire  [padframe_pkg::N_PADS-1:0] gpio_oe_i,
  input  wire                             uart_tx_i,
  input  wire                             spi_sck_i,
  input  wire                             i2c_sda_i,
  input  wire  [padframe_pkg::N_PADS-1:0] pad_in_i,
  output logic [padframe_pkg::N_PADS-1:0] pad_out_o,
  output logic [padframe_pkg::N_PADS-1:0] pad_oe_o,
  output logic [padframe_pkg::N_PADS-1:0] gpio_in_o,
  output logic                            uart_rx_o
);

  always_comb begin
    for (int p = 0; p < padframe_pkg::N_PADS; p++) begin
      case (pad_sel_i[p])
        padframe_pkg::SEL_UART: begin
          pad_out_o[p] = uart_tx_i;
          pad_oe_o[p]  = 1'b1;
        end
        padframe_pkg::SEL_SPI: begin
          pad_out_o[p] = spi_sck_i;
          pad_oe_o[p]  = 1'b1;
        end
        padframe_pkg::SEL_I2C: begin
          // Open drain, only ever pulls low
          pad_out_o[p] = 1'b0;
          pad_oe_o[p]  = ~i2c_sda_i;
        end
        default: begin
          pad_out_o[p] = gpio_out_i[p];
          pad_oe_o[p]  = gpio_oe_i[p];
        end
      endcase
    end
  end

  // Walk down so the lowest UART pad wins, idle line high
  always_comb begin
    uart_rx_o = 1'b1;
    for (int p = padframe_pkg::N_PADS - 1; p >= 0; p--) begin
      if (pad_sel_i[p] == padframe_pkg::SEL_UART) begin
        uart_rx_o = pad_in_i[p];
      end
    end
  end

  assign gpio_in_o = pad_in_i;

endmodule

`default_nettype wire

// ==== hw/soc_top.sv ====
`default_nettype none

module soc_top (
  input  wire                                               soc_clk_i,
  input  wire                                               cluster_clk_i,
  input  wire                                               rst_n_i,
  // Host memory requests
  input  wire                                               req_valid_i,
  output logic                                              req_ready_o,
  input  wire  [soc_cfg_pkg::ADDR_W-1:0]                    req_addr_i,
  input  wire  [soc_cfg_pkg::DATA_W-1:0]                    req_wdata_i,
  input  wire                                               req_we_i,
  output logic                                              rsp_valid_o,
  input  wire                                               rsp_ready_i,
  output logic [soc_cfg_pkg::DATA_W-1:0]                    rsp_rdata_o,
  // Pad frame configuration
  input  wire                                               cfg_valid_i,
  input  wire                                               cfg_write_i,
  input  wire  [padframe_pkg::CFG_ADDR_W-1:0]               cfg_addr_i,
  input  wire  padframe_pkg::pad_sel_t                      cfg_wdata_i,
  output logic                                              cfg_rvalid_o,
  output padframe_pkg::pad_sel_t                            cfg_rdata_o,
  // Peripherals and pads
  input  wire  [padframe_pkg::N_PADS-1:0]                   gpio_out_i,
  input  wire  [padframe_pkg::N_PADS-1:0]                   gpio_oe_i,
  output logic [padframe_pkg::N_PADS-1:0]                   gpio_in_o,
  input  wire                                               uart_tx_i,
  output logic                                              uart_rx_o,
  input  wire                                               spi_sck_i,
  input  wire                                               i2c_sda_i,
  input  wire  [padframe_pkg::N_PADS-1:0]                   pad_in_i,
  output logic [padframe_pkg::N_PADS-1:0]                   pad_out_o,
  output logic [padframe_pkg::N_PADS-1:0]                   pad_oe_o
);

  soc_cfg_pkg::mem_req_t host_req;
  soc_cfg_pkg::mem_req_t cluster_req;
  soc_cfg_pkg::mem_rsp_t cluster_rsp;
  soc_cfg_pkg::mem_rsp_t host_rsp;

  logic req_push;
  logic req_full;
  logic cluster_req_valid;
  logic cluster_req_pop;
  logic rsp_push;
  logic rsp_full;
  logic rsp_pop;

  padframe_pkg::pad_sel_t [padframe_pkg::N_PADS-1:0] pad_sel;

  assign host_req.addr  = req_addr_i;
  assign host_req.wdata = req_wdata_i;
  assign host_req.we    = req_we_i;

  assign rsp_rdata_o = host_rsp.rdata;
  assign rsp_pop     = rsp_valid_o & rsp_ready_i;

  txn_serializer i_txn_serializer (
    .clk_i       ( soc_clk_i   ),
    .rst_n_i     ( rst_n_i     ),
    .req_valid_i ( req_valid_i ),
    .req_ready_o ( req_ready_o ),
    .fifo_full_i ( req_full    ),
    .fifo_push_o ( req_push    ),
    .rsp_pop_i   ( rsp_pop     )
  );

  // soc -> cluster
  cdc_fifo_gray #(
    .payload_t ( soc_cfg_pkg::mem_req_t )
  ) i_req_cdc_fifo (
    .wr_clk_i   ( soc_clk_i         ),
    .rd_clk_i   ( cluster_clk_i     ),
    .rst_n_i    ( rst_n_i           ),
    .wr_valid_i ( req_push          ),
    .wr_data_i  ( host_req          ),
    .wr_full_o  ( req_full          ),
    .rd_valid_o ( cluster_req_valid ),
    .rd_ready_i ( cluster_req_pop   ),
    .rd_data_o  ( cluster_req       )
  );

  cluster_mem i_cluster_mem (
    .clk_i       ( cluster_clk_i     ),
    .rst_n_i     ( rst_n_i           ),
    .req_valid_i ( cluster_req_valid ),
    .req_i       ( cluster_req       ),
    .req_pop_o   ( cluster_req_pop   ),
    .rsp_full_i  ( rsp_full          ),
    .rsp_push_o  ( rsp_push          ),
    .rsp_o       ( cluster_rsp       )
  );

  // cluster -> soc
  cdc_fifo_gray #(
    .payload_t ( soc_cfg_pkg::mem_rsp_t )
  ) i_rsp_cdc_fifo (
    .wr_clk_i   ( cluster_clk_i ),
    .rd_clk_i   ( soc_clk_i     ),
    .rst_n_i    ( rst_n_i       ),
    .wr_valid_i ( rsp_push      ),
    .wr_data_i  ( cluster_rsp   ),
    .wr_full_o  ( rsp_full      ),
    .rd_valid_o ( rsp_valid_o   ),
    .rd_ready_i ( rsp_ready_i   ),
    .rd_data_o  ( host_rsp      )
  );

  padframe_cfg_regs i_padframe_cfg_regs (
    .clk_i        ( soc_clk_i    ),
    .rst_n_i      ( rst_n_i      ),
    .cfg_valid_i  ( cfg_valid_i  ),
    .cfg_write_i  ( cfg_write_i  ),
    .cfg_addr_i   ( cfg_addr_i   ),
    .cfg_wdata_i  ( cfg_wdata_i  ),
    .cfg_rvalid_o ( cfg_rvalid_o ),
    .cfg_rdata_o  ( cfg_rdata_o  ),
    .pad_sel_o    ( pad_sel      )
  );

  padframe_mux i_padframe_mux (
    .pad_sel_i  ( pad_sel    ),
    .gpio_out_i ( gpio_out_i ),
    .gpio_oe_i  ( gpio_oe_i  ),
    .uart_tx_i  ( uart_tx_i  ),
    .spi_sck_i  ( spi_sck_i  ),
    .i2c_sda_i  ( i2c_sda_i  ),
    .pad_in_i   ( pad_in_i   ),
    .pad_out_o  ( pad_out_o  ),
    .pad_oe_o   ( pad_oe_o   ),
    .gpio_in_o  ( gpio_in_o  ),
    .uart_rx_o  ( uart_rx_o  )
  );

endmodule

`default_nettype wire

// ==== bench/tb_soc_top.sv ====
`default_nettype none

module tb_soc_top;

  logic                                soc_clk_i;
  logic                                cluster_clk_i;
  logic                                rst_n_i;
  logic                                req_valid_i;
  logic                                req_ready_o;
  logic [soc_cfg_pkg::ADDR_W-1:0]      req_addr_i;
  logic [soc_cfg_pkg::DATA_W-1:0]      req_wdata_i;
  logic                                req_we_i;
  logic                                rsp_valid_o;
  logic                                rsp_ready_i;
  logic [soc_cfg_pkg::DATA_W-1:0]      rsp_rdata_o;
  logic                                cfg_valid_i;
  logic                                cfg_write_i;
  logic [padframe_pkg::CFG_ADDR_W-1:0] cfg_addr_i;
  padframe_pkg::pad_sel_t              cfg_wdata_i;
  logic                                cfg_rvalid_o;
  padframe_pkg::pad_sel_t              cfg_rdata_o;
  logic [padframe_pkg::N_PADS-1:0]     gpio_out_i;
  logic [padframe_pkg::N_PADS-1:0]     gpio_oe_i;
  logic [padframe_pkg::N_PADS-1:0]     gpio_in_o;
  logic                                uart_tx_i;
  logic                                uart_rx_o;
  logic                                spi_sck_i;
  logic                                i2c_sda_i;
  logic [padframe_pkg::N_PADS-1:0]     pad_in_i;
  logic [padframe_pkg::N_PADS-1:0]     pad_out_o;
  logic [padframe_pkg::N_PADS-1:0]     pad_oe_o;

  // Reference models
  logic [soc_cfg_pkg::DATA_W-1:0] mem_model [int];
  logic [soc_cfg_pkg::DATA_W-1:0] exp_q [$];
  bit                             chk_q [$];
  padframe_pkg::pad_sel_t         sel_model [padframe_pkg::N_PADS];

  int          n_errors;
  int          n_checks;
  int          issued;
  int          accepted;
  int          received;
  bit          req_pending;
  int unsigned seed_val;

  soc_top soc_top_inst (.*);

  always #10 soc_clk_i = ~soc_clk_i;
  always #17 cluster_clk_i = ~cluster_clk_i;

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    n_errors++;
    $display("Timeout at %0t while waiting for %s", $time, what);
    $display("Checks: %0d, errors: %0d", n_checks, n_errors);
    $display(">>> FAIL");
    $finish;
  endtask

  task automatic drive_pad_inputs();
    logic [31:0] rnd;
    rnd        = $urandom();
    gpio_out_i = rnd[padframe_pkg::N_PADS-1:0];
    gpio_oe_i  = rnd[2*padframe_pkg::N_PADS-1:padframe_pkg::N_PADS];
    pad_in_i   = rnd[3*padframe_pkg::N_PADS-1:2*padframe_pkg::N_PADS];
    uart_tx_i  = rnd[24];
    spi_sck_i  = rnd[25];
    i2c_sda_i  = rnd[26];
  endtask

  task automatic check_pad_outputs();
    logic [padframe_pkg::N_PADS-1:0] exp_out;
    logic [padframe_pkg::N_PADS-1:0] exp_oe;
    logic                            exp_rx;
    bit                              found;
    exp_rx = 1'b1;
    found  = 1'b0;
    for (int p = 0; p < padframe_pkg::N_PADS; p++) begin
      exp_out[p] = gpio_out_i[p];
      exp_oe[p]  = gpio_oe_i[p];
      if (sel_model[p] == padframe_pkg::SEL_UART) begin
        exp_out[p] = uart_tx_i;
        exp_oe[p]  = 1'b1;
        if (!found) exp_rx = pad_in_i[p];
        found = 1'b1;
      end else if (sel_model[p] == padframe_pkg::SEL_SPI) begin
        exp_out[p] = spi_sck_i;
        exp_oe[p]  = 1'b1;
      end else if (sel_model[p] == padframe_pkg::SEL_I2C) begin
        exp_out[p] = 1'b0;
        exp_oe[p]  = !i2c_sda_i;
      end
    end
    check_val("pad_out_o", 32'(pad_out_o), 32'(exp_out));
    check_val("pad_oe_o", 32'(pad_oe_o), 32'(exp_oe));
    check_val("uart_rx_o", 32'(uart_rx_o), 32'(exp_rx));
    check_val("gpio_in_o", 32'(gpio_in_o), 32'(pad_in_i));
  endtask

  // One register access, then checks one cycle after the DUT samples it
  task automatic cfg_access();
    logic [31:0]            rnd;
    int                     addr;
    padframe_pkg::pad_sel_t exp_rd;
    rnd  = $urandom();
    addr = $urandom_range((1 << padframe_pkg::CFG_ADDR_W) - 1);
    @(posedge soc_clk_i);
    #2;
    cfg_valid_i = 1'b1;
    cfg_write_i = rnd[0];
    cfg_addr_i  = padframe_pkg::CFG_ADDR_W'(addr);
    cfg_wdata_i = rnd[padframe_pkg::SEL_W:1];
    drive_pad_inputs();
    exp_rd = '0;
    if (addr < padframe_pkg::N_PADS) begin
      exp_rd = sel_model[addr];
      if (rnd[0]) sel_model[addr] = rnd[padframe_pkg::SEL_W:1];
    end
    @(posedge soc_clk_i);
    #2;
    cfg_valid_i = 1'b0;
    drive_pad_inputs();
    @(negedge soc_clk_i);
    check_val("cfg_rvalid_o", 32'(cfg_rvalid_o), 32'(!rnd[0]));
    if (!rnd[0]) check_val("cfg_rdata_o", 32'(cfg_rdata_o), 32'(exp_rd));
    check_pad_outputs();
  endtask

  // Drive after the edge, then sample handshakes at the falling edge
  task automatic host_cycle(input int issue_pct, input int rdy_pct);
    logic [soc_cfg_pkg::DATA_W-1:0] exp_data;
    @(posedge soc_clk_i);
    #2;
    if (!req_pending) begin
      if (issue_pct > 0 && $urandom_range(99) < issue_pct) begin
        req_valid_i = 1'b1;
        req_we_i    = $urandom_range(1) != 0;
        req_addr_i  = soc_cfg_pkg::ADDR_W'($urandom_range(31));
        req_wdata_i = $urandom();
        req_pending = 1'b1;
        issued++;
      end else begin
        req_valid_i = 1'b0;
      end
    end
    rsp_ready_i = $urandom_range(99) < rdy_pct;
    @(negedge soc_clk_i);
    if (rsp_valid_o && rsp_ready_i) begin
      received++;
      if (exp_q.size() == 0) begin
        n_errors++;
        $display("Response at %0t with no request outstanding", $time);
      end else begin
        exp_data = exp_q.pop_front();
        if (chk_q.pop_front()) check_val("rsp_rdata_o", rsp_rdata_o, exp_data);
      end
    end
    if (req_valid_i && req_ready_o) begin
      accepted++;
      req_pending = 1'b0;
      if (req_we_i) begin
        mem_model[int'(req_addr_i)] = req_wdata_i;
        exp_q.push_back(req_wdata_i);
        chk_q.push_back(1'b1);
      end else if (mem_model.exists(int'(req_addr_i))) begin
        exp_q.push_back(mem_model[int'(req_addr_i)]);
        chk_q.push_back(1'b1);
      end else begin
        // Never written so the content is unknown
        exp_q.push_back('0);
        chk_q.push_back(1'b0);
      end
    end
  endtask

  task automatic drain_responses();
    int guard;
    guard = 0;
    while (req_pending || exp_q.size() != 0) begin
      host_cycle(0, 100);
      guard++;
      if (guard > 2000) report_timeout("outstanding responses");
    end
    // Late or duplicate responses still get counted here
    repeat (20) host_cycle(0, 100);
  endtask

  initial begin
    int guard;
    int acc_start;
    int rec_start;
    soc_clk_i     = 1'b0;
    cluster_clk_i = 1'b0;
    rst_n_i       = 1'b0;
    req_valid_i   = 1'b0;
    req_addr_i    = '0;
    req_wdata_i   = '0;
    req_we_i      = 1'b0;
    rsp_ready_i   = 1'b0;
    cfg_valid_i   = 1'b0;
    cfg_write_i   = 1'b0;
    cfg_addr_i    = '0;
    cfg_wdata_i   = '0;
    gpio_out_i    = '0;
    gpio_oe_i     = '0;
    uart_tx_i     = 1'b0;
    spi_sck_i     = 1'b0;
    i2c_sda_i     = 1'b0;
    pad_in_i      = '0;
    n_errors      = 0;
    n_checks      = 0;
    issued        = 0;
    accepted      = 0;
    received      = 0;
    req_pending   = 1'b0;
    seed_val      = $urandom(61021);
    for (int p = 0; p < padframe_pkg::N_PADS; p++) sel_model[p] = padframe_pkg::SEL_GPIO;

    // Reset spans 5 cycles of the slower cluster clock
    repeat (5) @(posedge cluster_clk_i);
    @(posedge soc_clk_i);
    #2;
    rst_n_i = 1'b1;
    @(posedge soc_clk_i);
    #2;
    drive_pad_inputs();
    @(negedge soc_clk_i);
    check_val("req_ready_o", 32'(req_ready_o), 32'd1);
    check_val("rsp_valid_o", 32'(rsp_valid_o), 32'd0);
    check_val("cfg_rvalid_o", 32'(cfg_rvalid_o), 32'd0);
    check_pad_outputs();

    repeat (80) cfg_access();

    guard = 0;
    while (issued < 200) begin
      host_cycle(60, 50);
      guard++;
      if (guard > 20000) report_timeout("random requests to be issued");
    end
    drain_responses();
    check_val("response count", 32'(received), 32'(accepted));

    // Host stalls responses and the serializer holds at the limit
    acc_start = accepted;
    rec_start = received;
    guard     = 0;
    while (accepted - acc_start < soc_cfg_pkg::MAX_TXNS) begin
      host_cycle(100, 0);
      guard++;
      if (guard > 200) report_timeout("requests up to the outstanding limit");
    end
    repeat (50) begin
      host_cycle(100, 0);
      check_val("req_ready_o", 32'(req_ready_o), 32'd0);
    end
    check_val("accepted requests", 32'(accepted - acc_start), soc_cfg_pkg::MAX_TXNS);
    drain_responses();
    if (received - rec_start < soc_cfg_pkg::MAX_TXNS) begin
      n_errors++;
      $display("Only %0d responses came back after the stall", received - rec_start);
    end
    check_val("response count", 32'(received), 32'(accepted));

    $display("Checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
common/soc_cfg_pkg.sv
common/padframe_pkg.sv
cdc/cdc_fifo_gray.sv
hw/txn_serializer.sv
hw/cluster_mem.sv
padframe/padframe_cfg_regs.sv
padframe/padframe_mux.sv
hw/soc_top.sv
bench/tb_soc_top.sv

// ==== Makefile ====
TOP := tb_soc_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -o sim_$(TOP)

run: compile
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q '^>>> PASS$$' sim.log

clean:
	rm -rf obj_dir sim.log
